/* Makefile */
VERILATOR  ?= verilator
TOP        := mips_sys_tb
FILELIST   := list.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS := --lint-only --timing --assert --timescale 1ns/1ps
PASS_MSG   := Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* dv/mips_core_assert.sv */
`timescale 1ns/1ps

module mips_core_assert (
    input logic        clk,
    input logic        rst,
    input logic        active,
    input logic [31:0] instr_address,
    input logic        data_write,
    input logic        rd_write,
    input logic [4:0]  rd_addr
);

    // no store strobe while reset is high
    no_store_in_reset: assert property (@(posedge clk) rst |-> !data_write)
        else $error("store strobe high while the core is held in reset");

    // halted core keeps fetching from zero
    halt_holds_pc: assert property (@(posedge clk) !rst && !active |=> instr_address == 32'h0)
        else $error("program counter left zero after the core halted");

    // r0 is never a write destination
    no_r0_write: assert property (@(posedge clk) rd_write |-> rd_addr != 5'd0)
        else $error("register write strobe names r0");

endmodule

bind mips_core mips_core_assert i_core_assert (
    .clk           (clk),
    .rst           (rst),
    .active        (active),
    .instr_address (instr_address),
    .data_write    (data_write),
    .rd_write      (rd_write),
    .rd_addr       (rd_addr)
);

/* dv/mips_sys_tb.sv */
`timescale 1ns/1ps

module mips_sys_tb;

    localparam int num_runs = 40;
    // each run is at most 14 cycles plus 4 of reset, so 20 per run is ample
    localparam int timeout_cycles = num_runs * 20 + 100;

    logic        clk;
    logic        rst;
    logic        active;
    logic [31:0] register_v0;
    logic [31:0] instr_address;
    logic        data_write;
    logic [31:0] data_address;
    logic [31:0] data_writedata;

    integer seed;
    int     cycles;
    int     run;
    string  test_name;

    // reference model state
    logic [31:0] m_pc;
    logic [31:0] m_npc;
    logic [31:0] m_regs [0:31];
    logic [31:0] m_ram [0:mips_pkg::ram_words-1];

    mips_sys i_dut (
        .clk            (clk),
        .rst            (rst),
        .active         (active),
        .register_v0    (register_v0),
        .instr_address  (instr_address),
        .data_write     (data_write),
        .data_address   (data_address),
        .data_writedata (data_writedata)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > timeout_cycles) begin
            $display("Timeout: the test did not finish within %0d cycles", timeout_cycles);
            $display("Finished with errors");
            $fatal(1, "timeout");
        end
    end

    // branch-test program as hand-assembled words
    function automatic logic [31:0] program_word(input logic [31:0] addr);
        case (addr)
            // lw r2, 0(r0)
            32'hBFC0_0000: return 32'h8C02_0000;
            // jr r2
            32'hBFC0_0004: return 32'h0040_0008;
            32'hBFC0_000C: return 32'h0000_0008;
            // bne r20, r2, -0x8000 words
            32'h2000_0000: return 32'h1682_8000;
            32'h2000_0008: return 32'h0000_0008;
            // sw r2, 0x100(r0)
            32'h1FFE_0004: return 32'hAC02_0100;
            // jr r0
            32'h1FFE_0008: return 32'h0000_0008;
            default: return 32'h0;
        endcase
    endfunction

    // one rising edge of the model
    task automatic model_edge(input logic in_reset);
        logic [31:0] word;
        logic [31:0] rs_val;
        logic [31:0] rt_val;
        logic [31:0] imm;
        logic [31:0] addr;
        logic [31:0] npc_next;
        word     = program_word(m_pc);
        rs_val   = m_regs[word[25:21]];
        rt_val   = m_regs[word[20:16]];
        imm      = {{16{word[15]}}, word[15:0]};
        addr     = rs_val + imm;
        npc_next = m_npc + 32'd4;
        if (!in_reset && m_pc != 32'h0) begin
            case (word[31:26])
                mips_pkg::op_lw: begin
                    if (word[20:16] != 5'd0) begin
                        m_regs[word[20:16]] = m_ram[addr[8:2]];
                    end
                end
                mips_pkg::op_sw: begin
                    m_ram[addr[8:2]] = rt_val;
                end
                mips_pkg::op_beq: begin
                    if (rs_val == rt_val) begin
                        npc_next = m_npc + (imm << 2);
                    end
                end
                mips_pkg::op_bne: begin
                    if (rs_val != rt_val) begin
                        npc_next = m_npc + (imm << 2);
                    end
                end
                mips_pkg::op_special: begin
                    if (word[5:0] == mips_pkg::funct_jr) begin
                        npc_next = rs_val;
                    end
                end
                default: ;
            endcase
            m_pc  = m_npc;
            m_npc = npc_next;
        end
        if (in_reset) begin
            for (int i = 0; i < 32; i++) begin
                m_regs[i] = 32'h0;
            end
            m_ram[0] = mips_pkg::boot_word;
            m_pc     = mips_pkg::reset_vector;
            m_npc    = mips_pkg::reset_vector + 32'd4;
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Fail %s %s: expected %h, actual %h", test_name, what, expected, actual);
            $display("Finished with errors");
            $fatal(1, "value mismatch");
        end
    endtask

    // outputs are stable at the falling edge
    task automatic check_state();
        logic [31:0] word;
        logic [31:0] exp_addr;
        logic        exp_store;
        word      = program_word(m_pc);
        exp_store = (m_pc != 32'h0) && (word[31:26] == mips_pkg::op_sw);
        exp_addr  = m_regs[word[25:21]] + {{16{word[15]}}, word[15:0]};
        check_value("instr_address", m_pc, instr_address);
        check_value("active", 32'(m_pc != 32'h0), 32'(active));
        check_value("register_v0", m_regs[2], register_v0);
        check_value("data_write", 32'(exp_store), 32'(data_write));
        if (exp_store) begin
            check_value("data_address", exp_addr, data_address);
            check_value("data_writedata", m_regs[word[20:16]], data_writedata);
        end
    endtask

    initial begin
        int run_len;
        int hold;
        seed   = 32'hae7a;
        cycles = 0;
        clk    = 1'b0;
        rst    = 1'b1;
        m_pc   = mips_pkg::reset_vector;
        m_npc  = mips_pkg::reset_vector + 32'd4;
        for (int i = 0; i < mips_pkg::ram_words; i++) begin
            m_ram[i] = 32'h0;
        end
        model_edge(1'b1);
        repeat (16) @(negedge clk);

        for (run = 0; run < num_runs; run++) begin
            // short runs get cut by reset, long ones reach the halt
            run_len = 1 + ($unsigned($random(seed)) % 14);
            hold    = 1 + ($unsigned($random(seed)) % 4);
            rst     = 1'b0;
            for (int cyc = 0; cyc < run_len; cyc++) begin
                test_name = $sformatf("run %0d cycle %0d", run, cyc);
                check_state();
                @(negedge clk);
                model_edge(1'b0);
            end
            test_name = $sformatf("run %0d cycle %0d", run, run_len);
            check_state();
            rst = 1'b1;
            for (int h = 0; h < hold; h++) begin
                @(negedge clk);
                model_edge(1'b1);
                test_name = $sformatf("run %0d reset cycle %0d", run, h);
                check_state();
            end
        end

        $display("Finished with no errors");
        $finish;
    end

endmodule

/* hw/branch_test_rom.sv */
`timescale 1ns/1ps

module branch_test_rom (
    input  logic [31:0] instr_address,
    output logic [31:0] instr_readdata
);

    // immediate format word
    function automatic logic [31:0] i_word(
        input logic [5:0]  opcode,
        input logic [4:0]  rs,
        input logic [4:0]  rt,
        input logic [15:0] imm
    );
        mips_pkg::instr_word_t w;
        w.i_fmt.opcode = opcode;
        w.i_fmt.rs     = rs;
        w.i_fmt.rt     = rt;
        w.i_fmt.imm    = imm;
        return w;
    endfunction

    // jr through a register, all other fields zero
    function automatic logic [31:0] jr_word(input logic [4:0] rs);
        mips_pkg::instr_word_t w;
        w.r_fmt.opcode = mips_pkg::op_special;
        w.r_fmt.rs     = rs;
        w.r_fmt.rt     = 5'd0;
        w.r_fmt.rd     = 5'd0;
        w.r_fmt.shamt  = 5'd0;
        w.r_fmt.funct  = mips_pkg::funct_jr;
        return w;
    endfunction

    always_comb begin
        // anything not listed reads as nop
        instr_readdata = 32'h0;
        case (instr_address)
            // boot region
            32'hBFC0_0000: begin
                // lw r2, 0(r0) picks up the jump target
                instr_readdata = i_word(mips_pkg::op_lw, 5'd0, 5'd2, 16'h0000);
            end
            32'hBFC0_0004: begin
                instr_readdata = jr_word(5'd2);
            end
            32'hBFC0_0008: instr_readdata = 32'h0;
            32'hBFC0_000C: begin
                // unreachable fallback halt
                instr_readdata = jr_word(5'd0);
            end
            32'hBFC0_0010: instr_readdata = 32'h0;
            // jump target region
            32'h2000_0000: begin
                // r20 is zero and r2 is not, so this is taken backwards
                instr_readdata = i_word(mips_pkg::op_bne, 5'd20, 5'd2, 16'h8000);
            end
            32'h2000_0004: instr_readdata = 32'h0;
            32'h2000_0008: begin
                instr_readdata = jr_word(5'd0);
            end
            32'h2000_000C: instr_readdata = 32'h0;
            // branch target region
            32'h1FFE_0004: begin
                // sw r2, 0x100(r0)
                instr_readdata = i_word(mips_pkg::op_sw, 5'd0, 5'd2, 16'h0100);
            end
            32'h1FFE_0008: begin
                // halt once the delay slot has run
                instr_readdata = jr_word(5'd0);
            end
            32'h1FFE_000C: instr_readdata = 32'h0;
            default: instr_readdata = 32'h0;
        endcase
    end

endmodule

/* hw/data_ram.sv */
`timescale 1ns/1ps

module data_ram (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] data_address,
    input  logic        data_write,
    input  logic [31:0] data_writedata,
    output logic [31:0] data_readdata
);

    logic [31:0] mem [0:mips_pkg::ram_words-1];
    logic [mips_pkg::ram_addr_bits-1:0] word_index;

    // byte address to word index
    assign word_index = data_address[mips_pkg::ram_addr_bits+1:2];

    always_ff @(posedge clk) begin
        if (data_write) begin
            mem[word_index] <= data_writedata;
        end
        // reseed the jump target, the rest of memory survives reset
        if (rst) begin
            mem[0] <= mips_pkg::boot_word;
        end
    end

    assign data_readdata = mem[word_index];

endmodule

/* hw/mips_core.sv */
`timescale 1ns/1ps

module mips_core (
    input  logic        clk,
    input  logic        rst,
    output logic [31:0] instr_address,
    input  logic [31:0] instr_readdata,
    output logic [4:0]  rs_addr,
    output logic [4:0]  rt_addr,
    output logic [4:0]  rd_addr,
    output logic        rd_write,
    output logic [31:0] rd_data,
    input  logic [31:0] rs_data,
    input  logic [31:0] rt_data,
    output logic [31:0] data_address,
    output logic        data_write,
    output logic [31:0] data_writedata,
    input  logic [31:0] data_readdata,
    output logic        active
);

    logic [31:0] pc;
    logic [31:0] next_pc;
    logic [31:0] next_pc_d;

    mips_pkg::instr_word_t instr;

    logic        is_lw;
    logic        is_sw;
    logic        is_beq;
    logic        is_bne;
    logic        is_jr;
    logic        operands_equal;
    logic        branch_taken;
    logic [31:0] imm_ext;
    logic [31:0] branch_target;

    assign instr = instr_readdata;

    // decode
    assign is_lw  = instr.i_fmt.opcode == mips_pkg::op_lw;
    assign is_sw  = instr.i_fmt.opcode == mips_pkg::op_sw;
    assign is_beq = instr.i_fmt.opcode == mips_pkg::op_beq;
    assign is_bne = instr.i_fmt.opcode == mips_pkg::op_bne;
    assign is_jr  = instr.r_fmt.opcode == mips_pkg::op_special
                 && instr.r_fmt.funct == mips_pkg::funct_jr;

    // rs is shared by both formats; rt is the load destination
    assign rs_addr = instr.r_fmt.rs;
    assign rt_addr = instr.i_fmt.rt;
    assign rd_addr = instr.i_fmt.rt;

    assign imm_ext = {{16{instr.i_fmt.imm[15]}}, instr.i_fmt.imm};

    // load/store, strobes stay low while reset is held
    assign data_address   = rs_data + imm_ext;
    assign data_writedata = rt_data;
    assign data_write     = active && is_sw && !rst;

    // load writes back at the end of its own cycle
    assign rd_data  = data_readdata;
    assign rd_write = active && is_lw && !rst;

    // branch resolution, relative to the delay slot address
    assign operands_equal = rs_data == rt_data;
    assign branch_taken   = (is_beq && operands_equal) || (is_bne && !operands_equal);
    assign branch_target  = next_pc + {imm_ext[29:0], 2'b00};

    always_comb begin
        if (is_jr) begin
            next_pc_d = rs_data;
        end else if (branch_taken) begin
            next_pc_d = branch_target;
        end else begin
            next_pc_d = next_pc + 32'd4;
        end
    end

    // pc zero means halted
    assign active = pc != 32'h0;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc      <= mips_pkg::reset_vector;
            next_pc <= mips_pkg::reset_vector + 32'd4;
        end else if (active) begin
            // the instruction after a branch still runs
            pc      <= next_pc;
            next_pc <= next_pc_d;
        end
    end

    assign instr_address = pc;

endmodule

/* hw/mips_pkg.sv */
package mips_pkg;

    // first fetch address after reset
    localparam logic [31:0] reset_vector = 32'hBFC0_0000;

    // primary opcodes
    localparam logic [5:0] op_special = 6'b000000;
    localparam logic [5:0] op_beq     = 6'b000100;
    localparam logic [5:0] op_bne     = 6'b000101;
    localparam logic [5:0] op_lw      = 6'b100011;
    localparam logic [5:0] op_sw      = 6'b101011;

    // special funct codes
    localparam logic [5:0] funct_jr = 6'b001000;

    // data memory geometry, word index from byte address bits 8..2
    localparam int ram_words     = 128;
    localparam int ram_addr_bits = 7;

    // value seeded into data word 0, used as the jump target
    localparam logic [31:0] boot_word = 32'h2000_0000;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fmt_t;

    // one instruction word, seen as register or immediate format
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_word_t;

endpackage

/* hw/mips_sys.sv */
`timescale 1ns/1ps

module mips_sys (
    input  logic        clk,
    input  logic        rst,
    output logic        active,
    output logic [31:0] register_v0,
    output logic [31:0] instr_address,
    output logic        data_write,
    output logic [31:0] data_address,
    output logic [31:0] data_writedata
);

    logic [31:0] instr_readdata;
    logic [4:0]  rs_addr;
    logic [4:0]  rt_addr;
    logic [4:0]  rd_addr;
    logic        rd_write;
    logic [31:0] rd_data;
    logic [31:0] rs_data;
    logic [31:0] rt_data;
    logic [31:0] data_readdata;

    mips_core i_core (
        .clk            (clk),
        .rst            (rst),
        .instr_address  (instr_address),
        .instr_readdata (instr_readdata),
        .rs_addr        (rs_addr),
        .rt_addr        (rt_addr),
        .rd_addr        (rd_addr),
        .rd_write       (rd_write),
        .rd_data        (rd_data),
        .rs_data        (rs_data),
        .rt_data        (rt_data),
        .data_address   (data_address),
        .data_write     (data_write),
        .data_writedata (data_writedata),
        .data_readdata  (data_readdata),
        .active         (active)
    );

    branch_test_rom i_rom (
        .instr_address  (instr_address),
        .instr_readdata (instr_readdata)
    );

    reg_file i_regs (
        .clk         (clk),
        .rst         (rst),
        .rs_addr     (rs_addr),
        .rt_addr     (rt_addr),
        .rd_addr     (rd_addr),
        .rd_write    (rd_write),
        .rd_data     (rd_data),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .register_v0 (register_v0)
    );

    data_ram i_ram (
        .clk            (clk),
        .rst            (rst),
        .data_address   (data_address),
        .data_write     (data_write),
        .data_writedata (data_writedata),
        .data_readdata  (data_readdata)
    );

endmodule

/* hw/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic        clk,
    input  logic        rst,
    input  logic [4:0]  rs_addr,
    input  logic [4:0]  rt_addr,
    input  logic [4:0]  rd_addr,
    input  logic        rd_write,
    input  logic [31:0] rd_data,
    output logic [31:0] rs_data,
    output logic [31:0] rt_data,
    output logic [31:0] register_v0
);

    logic [31:0] regs [0:31];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'h0;
            end
        end else if (rd_write && rd_addr != 5'd0) begin
            regs[rd_addr] <= rd_data;
        end
    end

    // r0 always reads zero
    assign rs_data = (rs_addr == 5'd0) ? 32'h0 : regs[rs_addr];
    assign rt_data = (rt_addr == 5'd0) ? 32'h0 : regs[rt_addr];

    // v0 for observation
    assign register_v0 = regs[2];

endmodule

/* list.f */
hw/mips_pkg.sv
hw/branch_test_rom.sv
hw/reg_file.sv
hw/data_ram.sv
hw/mips_core.sv
hw/mips_sys.sv
dv/mips_core_assert.sv
dv/mips_sys_tb.sv
